/* hw/pat_pkg.sv */
`default_nettype none

package pat_pkg;

	// ====================================================================
	// widths
	// ====================================================================
	localparam int INSTR_W = 23; // program word
	localparam int DATA_W = 8; // datapath
	localparam int PC_W = 10; // program address
	localparam int REG_ADR_W = 3; // 8 registers
	localparam int SHIFT_AMT_W = 2; // field value 0..3 means shift by 1..4
	localparam int OPC_W = 4;
	localparam int COND_W = 2;

	// ====================================================================
	// opcodes
	// ====================================================================
	// i8 space, immediate forms; low bit set selects the register form
	localparam logic [OPC_W-1:0] OPC_I8_OR = 4'b0000;
	localparam logic [OPC_W-1:0] OPC_I8_AND = 4'b0010;
	localparam logic [OPC_W-1:0] OPC_I8_ADD = 4'b0100;
	localparam logic [OPC_W-1:0] OPC_I8_SUB = 4'b0110;
	localparam logic [OPC_W-1:0] OPC_I8_LDI = 4'b1000; // or with a forced to zero
	localparam logic [OPC_W-1:0] OPC_I8_BF = 4'b1101; // relative branch, imm8 offset
	localparam logic [OPC_W-1:0] OPC_PREFIX = 4'b1111; // escape into i3, then i0

	// i3 space, shifts use the low bit for the register form as well
	localparam logic [OPC_W-1:0] OPC_I3_SHLZ = 4'b0000;
	localparam logic [OPC_W-1:0] OPC_I3_SHLO = 4'b0010;
	localparam logic [OPC_W-1:0] OPC_I3_SHRZ = 4'b0100;
	localparam logic [OPC_W-1:0] OPC_I3_SHRO = 4'b0110; // asr in the older core
	localparam logic [OPC_W-1:0] OPC_I3_IN = 4'b1000; // imm3 is a one-hot port select
	localparam logic [OPC_W-1:0] OPC_I3_OUT = 4'b1011;

	// i0 space
	localparam logic [OPC_W-1:0] OPC_I0_NOT = 4'b0000;
	localparam logic [OPC_W-1:0] OPC_I0_TEST = 4'b0010;
	localparam logic [OPC_W-1:0] OPC_I0_NOP = 4'b0101;

	// branch conditions
	localparam logic [COND_W-1:0] COND_Z = 2'd0;
	localparam logic [COND_W-1:0] COND_NZ = 2'd1;
	localparam logic [COND_W-1:0] COND_N = 2'd2;
	localparam logic [COND_W-1:0] COND_AL = 2'd3;

	localparam logic [INSTR_W-1:0] INSTR_NOP =
		{3'b000, 6'b000000, COND_AL, OPC_PREFIX, OPC_PREFIX, OPC_I0_NOP};

	// ====================================================================
	// types
	// ====================================================================
	typedef enum logic [3:0] {
		ALU_OR, // also ldi
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_SHRO,
		ALU_PASS // y = a, for in, out, test, nop, bf
	} alu_op_e;

	typedef struct packed {
		logic [REG_ADR_W-1:0] rn; // source and destination
		logic [5:0] rsvd; // old field buffer bits, ignored
		logic [COND_W-1:0] cond;
		logic [OPC_W-1:0] opcode_i8;
		logic [DATA_W-1:0] imm8; // immediate, register number or branch offset
	} pat_i8_t;

	typedef struct packed {
		logic [REG_ADR_W-1:0] rn;
		logic [5:0] rsvd;
		logic [COND_W-1:0] cond;
		logic [OPC_W-1:0] prefix; // OPC_PREFIX here
		logic [OPC_W-1:0] opcode_i3; // OPC_PREFIX here means i0
		logic [OPC_W-1:0] low; // i0 opcode; imm3 in [2:0]
	} pat_i3_t;

	// one word, two decodings
	typedef union packed {
		pat_i8_t i8;
		pat_i3_t i3;
	} pat_instr_u;

endpackage

`default_nettype wire

/* hw/pat_fetch.sv */
`default_nettype none

module pat_fetch (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_redirect, // taken branch, one cycle
	input wire logic [pat_pkg::PC_W-1:0] i_redirect_pc,
	input wire logic [pat_pkg::INSTR_W-1:0] i_instr, // mem[o_pc], same cycle
	output logic [pat_pkg::PC_W-1:0] o_pc,
	output pat_pkg::pat_instr_u o_instr,
	output logic [pat_pkg::PC_W-1:0] o_instr_pc,
	output logic o_valid
);

	// pc and valid
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;
			o_valid <= 1'b0;
		end
		else if (i_redirect)
		begin
			o_pc <= i_redirect_pc; // jump to the branch target
			o_valid <= 1'b0; // word at o_pc is on the wrong path
		end
		else
		begin
			o_pc <= o_pc + 1'b1; // one word per cycle, no stalls
			o_valid <= 1'b1;
		end
	end

	// instruction register with the pc it came from
	always_ff @(posedge clk)
	begin
		o_instr <= i_instr;
		o_instr_pc <= o_pc;
	end

endmodule

`default_nettype wire

/* hw/pat_decode.sv */
`default_nettype none

module pat_decode (
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::pat_instr_u i_instr,
	input wire logic [pat_pkg::PC_W-1:0] i_instr_pc,
	input wire logic i_valid,
	input wire logic i_flush, // redirect from result
	input wire logic [pat_pkg::DATA_W-1:0] i_in0,
	input wire logic [pat_pkg::DATA_W-1:0] i_in1,
	input wire logic [pat_pkg::DATA_W-1:0] i_in2,
	output logic [pat_pkg::REG_ADR_W-1:0] o_rd_adr_a,
	output logic [pat_pkg::REG_ADR_W-1:0] o_rd_adr_b,
	input wire logic [pat_pkg::DATA_W-1:0] i_rd_data_a,
	input wire logic [pat_pkg::DATA_W-1:0] i_rd_data_b,
	output pat_pkg::alu_op_e o_alu_op,
	output logic [pat_pkg::DATA_W-1:0] o_a,
	output logic [pat_pkg::DATA_W-1:0] o_b,
	output logic [pat_pkg::REG_ADR_W-1:0] o_dest,
	output logic o_wr,
	output logic o_test,
	output logic o_out,
	output logic o_branch,
	output logic [pat_pkg::COND_W-1:0] o_cond,
	output logic [pat_pkg::DATA_W-1:0] o_offset,
	output logic [pat_pkg::PC_W-1:0] o_pc,
	output logic o_valid
);
	import pat_pkg::*;

	logic is_i8; // i8 view applies
	logic is_i3; // i3 view applies, i0 otherwise
	logic [2:0] imm3;
	logic reg_form; // b comes from a register
	logic ldi_op;
	logic in_op;
	logic known; // opcode recognised
	alu_op_e alu_op;
	logic wr, test, out, branch;
	logic [DATA_W-1:0] in_sel, a, b;

	assign is_i8 = (i_instr.i8.opcode_i8 != OPC_PREFIX);
	assign is_i3 = !is_i8 && (i_instr.i3.opcode_i3 != OPC_PREFIX);
	assign imm3 = i_instr.i3.low[2:0];

	assign o_rd_adr_a = i_instr.i8.rn;
	assign o_rd_adr_b = i_instr.i8.imm8[REG_ADR_W-1:0]; // imm3 shares these bits

	// ====================================================================
	// opcode decode
	// ====================================================================
	always_comb
	begin
		alu_op = ALU_PASS;
		reg_form = 1'b0;
		wr = 1'b0;
		test = 1'b0;
		out = 1'b0;
		branch = 1'b0;
		ldi_op = 1'b0;
		in_op = 1'b0;
		known = 1'b1;
		if (is_i8)
		begin
			reg_form = i_instr.i8.opcode_i8[0];
			wr = 1'b1;
			case (i_instr.i8.opcode_i8)
				OPC_I8_OR, OPC_I8_OR | 4'b0001: alu_op = ALU_OR;
				OPC_I8_AND, OPC_I8_AND | 4'b0001: alu_op = ALU_AND;
				OPC_I8_ADD, OPC_I8_ADD | 4'b0001: alu_op = ALU_ADD;
				OPC_I8_SUB, OPC_I8_SUB | 4'b0001: alu_op = ALU_SUB;
				OPC_I8_LDI:
				begin
					alu_op = ALU_OR; // 0 | imm8
					ldi_op = 1'b1;
				end
				OPC_I8_BF:
				begin
					wr = 1'b0;
					branch = 1'b1;
				end
				default:
				begin
					wr = 1'b0;
					known = 1'b0;
				end
			endcase
		end
		else if (is_i3)
		begin
			reg_form = i_instr.i3.opcode_i3[0];
			wr = 1'b1;
			case (i_instr.i3.opcode_i3)
				OPC_I3_SHLZ, OPC_I3_SHLZ | 4'b0001: alu_op = ALU_SHLZ;
				OPC_I3_SHLO, OPC_I3_SHLO | 4'b0001: alu_op = ALU_SHLO;
				OPC_I3_SHRZ, OPC_I3_SHRZ | 4'b0001: alu_op = ALU_SHRZ;
				OPC_I3_SHRO, OPC_I3_SHRO | 4'b0001: alu_op = ALU_SHRO;
				OPC_I3_IN: in_op = 1'b1; // port value rides on a, alu passes it
				OPC_I3_OUT:
				begin
					wr = 1'b0;
					out = 1'b1;
				end
				default:
				begin
					wr = 1'b0;
					known = 1'b0;
				end
			endcase
		end
		else
		begin
			case (i_instr.i3.low)
				OPC_I0_NOT:
				begin
					alu_op = ALU_NOT;
					wr = 1'b1;
				end
				OPC_I0_TEST: test = 1'b1;
				OPC_I0_NOP: alu_op = ALU_PASS; // nothing commits
				default: known = 1'b0;
			endcase
		end
	end

	// ====================================================================
	// operands
	// ====================================================================
	always_comb
	begin
		case (imm3)
			3'b010: in_sel = i_in1;
			3'b100: in_sel = i_in2;
			default: in_sel = i_in0; // 001 and any other select
		endcase
	end

	assign a = ldi_op ? '0 : (in_op ? in_sel : i_rd_data_a);
	assign b = reg_form ? i_rd_data_b :
		(is_i8 ? i_instr.i8.imm8 : {{(DATA_W-3){1'b0}}, imm3});

	always_ff @(posedge clk)
	begin
		if (reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid && !i_flush; // squashed behind a taken branch
	end

	always_ff @(posedge clk)
	begin
		o_alu_op <= alu_op;
		o_a <= a;
		o_b <= b;
		o_dest <= i_instr.i8.rn;
		o_wr <= wr;
		o_test <= test;
		o_out <= out;
		o_branch <= branch;
		o_cond <= i_instr.i8.cond; // same bits in both views
		o_offset <= i_instr.i8.imm8;
		o_pc <= i_instr_pc;
	end

	// the program memory only holds words this core can run
	a_known_opcode: assert property (@(posedge clk) disable iff (reset)
		i_valid |-> known);

endmodule

`default_nettype wire

/* hw/pat_regfile.sv */
`default_nettype none

module pat_regfile (
	input wire logic clk,
	input wire logic [pat_pkg::REG_ADR_W-1:0] i_rd_adr_a,
	input wire logic [pat_pkg::REG_ADR_W-1:0] i_rd_adr_b,
	output logic [pat_pkg::DATA_W-1:0] o_rd_data_a,
	output logic [pat_pkg::DATA_W-1:0] o_rd_data_b,
	input wire logic i_wr_en,
	input wire logic [pat_pkg::REG_ADR_W-1:0] i_wr_adr,
	input wire logic [pat_pkg::DATA_W-1:0] i_wr_data
);
	import pat_pkg::*;

	logic [DATA_W-1:0] regs [1 << REG_ADR_W]; // contents undefined until loaded

	// reads are combinational, no bypass from the write port
	assign o_rd_data_a = regs[i_rd_adr_a];
	assign o_rd_data_b = regs[i_rd_adr_b];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_adr] <= i_wr_data;
	end

	// write-back from result always names a register
	a_wr_adr_known: assert property (@(posedge clk) i_wr_en |-> !$isunknown(i_wr_adr));

endmodule

`default_nettype wire

/* hw/pat_execute.sv */
`default_nettype none

module pat_execute (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_flush,
	input wire pat_pkg::alu_op_e i_alu_op,
	input wire logic [pat_pkg::DATA_W-1:0] i_a,
	input wire logic [pat_pkg::DATA_W-1:0] i_b,
	input wire logic [pat_pkg::REG_ADR_W-1:0] i_dest,
	input wire logic i_wr,
	input wire logic i_test,
	input wire logic i_out,
	input wire logic i_branch,
	input wire logic [pat_pkg::COND_W-1:0] i_cond,
	input wire logic [pat_pkg::DATA_W-1:0] i_offset,
	input wire logic [pat_pkg::PC_W-1:0] i_pc,
	input wire logic i_valid,
	output logic [pat_pkg::DATA_W-1:0] o_result,
	output logic [pat_pkg::DATA_W-1:0] o_a, // register value for test and out
	output logic [pat_pkg::REG_ADR_W-1:0] o_dest,
	output logic o_wr,
	output logic o_test,
	output logic o_out,
	output logic o_branch,
	output logic [pat_pkg::COND_W-1:0] o_cond,
	output logic [pat_pkg::DATA_W-1:0] o_offset,
	output logic [pat_pkg::PC_W-1:0] o_pc,
	output logic o_valid
);
	import pat_pkg::*;

	logic [SHIFT_AMT_W:0] shamt; // 1..4
	logic [DATA_W-1:0] na; // complement of a
	logic [DATA_W-1:0] y;

	assign shamt = {1'b0, i_b[SHIFT_AMT_W-1:0]} + 1'b1;
	assign na = ~i_a;

	// ====================================================================
	// alu and shifter
	// ====================================================================
	always_comb
	begin
		case (i_alu_op)
			ALU_OR: y = i_a | i_b;
			ALU_AND: y = i_a & i_b;
			ALU_ADD: y = i_a + i_b; // wraps mod 256
			ALU_SUB: y = i_a - i_b;
			ALU_NOT: y = na;
			ALU_SHLZ: y = i_a << shamt;
			// one fill is a zero fill of the complement, inverted back
			ALU_SHLO: y = ~(na << shamt);
			ALU_SHRZ: y = i_a >> shamt;
			ALU_SHRO: y = ~(na >> shamt); // vacated top bits become ones
			default: y = i_a; // ALU_PASS
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid && !i_flush;
	end

	always_ff @(posedge clk)
	begin
		o_result <= y;
		o_a <= i_a;
		o_dest <= i_dest;
		o_wr <= i_wr;
		o_test <= i_test;
		o_out <= i_out;
		o_branch <= i_branch;
		o_cond <= i_cond;
		o_offset <= i_offset;
		o_pc <= i_pc;
	end

endmodule

`default_nettype wire

/* hw/pat_result.sv */
`default_nettype none

module pat_result (
	input wire logic clk,
	input wire logic reset,
	input wire logic [pat_pkg::DATA_W-1:0] i_result,
	input wire logic [pat_pkg::DATA_W-1:0] i_a,
	input wire logic [pat_pkg::REG_ADR_W-1:0] i_dest,
	input wire logic i_wr,
	input wire logic i_test,
	input wire logic i_out,
	input wire logic i_branch,
	input wire logic [pat_pkg::COND_W-1:0] i_cond,
	input wire logic [pat_pkg::DATA_W-1:0] i_offset,
	input wire logic [pat_pkg::PC_W-1:0] i_pc,
	input wire logic i_valid,
	output logic o_wr_en,
	output logic [pat_pkg::REG_ADR_W-1:0] o_wr_adr,
	output logic [pat_pkg::DATA_W-1:0] o_wr_data,
	output logic o_redirect,
	output logic [pat_pkg::PC_W-1:0] o_redirect_pc,
	output logic [pat_pkg::DATA_W-1:0] o_out_data,
	output logic o_out_valid,
	output logic o_flag_z,
	output logic o_flag_n
);
	import pat_pkg::*;

	logic cond_ok;

	// ====================================================================
	// branch resolve
	// ====================================================================
	always_comb
	begin
		case (i_cond)
			COND_Z: cond_ok = o_flag_z;
			COND_NZ: cond_ok = !o_flag_z; // tests z, not n
			COND_N: cond_ok = o_flag_n;
			default: cond_ok = 1'b1; // COND_AL
		endcase
	end

	// fetch and the two stage registers act on this at the commit edge
	assign o_redirect = i_valid && i_branch && cond_ok;
	assign o_redirect_pc = i_pc + {{(PC_W-DATA_W){i_offset[DATA_W-1]}}, i_offset};

	// ====================================================================
	// commit
	// ====================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_wr_en <= 1'b0;
			o_out_valid <= 1'b0;
			o_flag_z <= 1'b0;
			o_flag_n <= 1'b0;
		end
		else
		begin
			o_wr_en <= i_valid && i_wr;
			o_out_valid <= i_valid && i_out; // one-cycle strobe
			if (i_valid && i_test)
			begin
				o_flag_z <= (i_a == '0);
				o_flag_n <= i_a[DATA_W-1]; // sign bit
			end
		end
	end

	always_ff @(posedge clk)
	begin
		o_wr_adr <= i_dest;
		o_wr_data <= i_result;
		if (i_valid && i_out)
			o_out_data <= i_a; // holds until the next out
	end

	// the branch writes nothing, and the slot squashed behind it commits nothing
	a_redirect_no_wr: assert property (@(posedge clk) disable iff (reset)
		o_redirect |=> !o_wr_en [*2]);

endmodule

`default_nettype wire

/* hw/pat_core.sv */
`default_nettype none

module pat_core (
	input wire logic clk,
	input wire logic reset,
	output logic [pat_pkg::PC_W-1:0] o_pc,
	input wire logic [pat_pkg::INSTR_W-1:0] i_instr,
	input wire logic [pat_pkg::DATA_W-1:0] i_in0,
	input wire logic [pat_pkg::DATA_W-1:0] i_in1,
	input wire logic [pat_pkg::DATA_W-1:0] i_in2,
	output logic [pat_pkg::DATA_W-1:0] o_out_data,
	output logic o_out_valid,
	output logic o_flag_z,
	output logic o_flag_n
);
	import pat_pkg::*;

	// fetch stage
	pat_instr_u f_instr;
	logic [PC_W-1:0] f_pc;
	logic f_valid;

	// register file ports
	logic [REG_ADR_W-1:0] rd_adr_a, rd_adr_b, wr_adr;
	logic [DATA_W-1:0] rd_data_a, rd_data_b, wr_data;
	logic wr_en;

	// decode stage
	alu_op_e d_alu_op;
	logic [DATA_W-1:0] d_a, d_b, d_offset;
	logic [REG_ADR_W-1:0] d_dest;
	logic d_wr, d_test, d_out, d_branch, d_valid;
	logic [COND_W-1:0] d_cond;
	logic [PC_W-1:0] d_pc;

	// execute stage
	logic [DATA_W-1:0] e_result, e_a, e_offset;
	logic [REG_ADR_W-1:0] e_dest;
	logic e_wr, e_test, e_out, e_branch, e_valid;
	logic [COND_W-1:0] e_cond;
	logic [PC_W-1:0] e_pc;

	// redirect, also the flush of every younger stage
	logic redirect;
	logic [PC_W-1:0] redirect_pc;

	pat_fetch fetch_inst (
		.clk(clk), .reset(reset),
		.i_redirect(redirect), .i_redirect_pc(redirect_pc),
		.i_instr(i_instr), .o_pc(o_pc),
		.o_instr(f_instr), .o_instr_pc(f_pc), .o_valid(f_valid)
	);

	pat_decode decode_inst (
		.clk(clk), .reset(reset),
		.i_instr(f_instr), .i_instr_pc(f_pc), .i_valid(f_valid), .i_flush(redirect),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_rd_adr_a(rd_adr_a), .o_rd_adr_b(rd_adr_b),
		.i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b),
		.o_alu_op(d_alu_op), .o_a(d_a), .o_b(d_b), .o_dest(d_dest),
		.o_wr(d_wr), .o_test(d_test), .o_out(d_out), .o_branch(d_branch),
		.o_cond(d_cond), .o_offset(d_offset), .o_pc(d_pc), .o_valid(d_valid)
	);

	pat_regfile regfile_inst (
		.clk(clk),
		.i_rd_adr_a(rd_adr_a), .i_rd_adr_b(rd_adr_b),
		.o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b),
		.i_wr_en(wr_en), .i_wr_adr(wr_adr), .i_wr_data(wr_data)
	);

	pat_execute execute_inst (
		.clk(clk), .reset(reset), .i_flush(redirect),
		.i_alu_op(d_alu_op), .i_a(d_a), .i_b(d_b), .i_dest(d_dest),
		.i_wr(d_wr), .i_test(d_test), .i_out(d_out), .i_branch(d_branch),
		.i_cond(d_cond), .i_offset(d_offset), .i_pc(d_pc), .i_valid(d_valid),
		.o_result(e_result), .o_a(e_a), .o_dest(e_dest),
		.o_wr(e_wr), .o_test(e_test), .o_out(e_out), .o_branch(e_branch),
		.o_cond(e_cond), .o_offset(e_offset), .o_pc(e_pc), .o_valid(e_valid)
	);

	pat_result result_inst (
		.clk(clk), .reset(reset),
		.i_result(e_result), .i_a(e_a), .i_dest(e_dest),
		.i_wr(e_wr), .i_test(e_test), .i_out(e_out), .i_branch(e_branch),
		.i_cond(e_cond), .i_offset(e_offset), .i_pc(e_pc), .i_valid(e_valid),
		.o_wr_en(wr_en), .o_wr_adr(wr_adr), .o_wr_data(wr_data),
		.o_redirect(redirect), .o_redirect_pc(redirect_pc),
		.o_out_data(o_out_data), .o_out_valid(o_out_valid),
		.o_flag_z(o_flag_z), .o_flag_n(o_flag_n)
	);

endmodule

`default_nettype wire

/* tests/pat_clock_gen.sv */
`default_nettype none

module pat_clock_gen (
	output logic o_clk,
	output logic o_reset
);

	localparam int HALF_PERIOD = 50; // period 100

	initial
	begin
		o_clk = 1'b0;
		o_reset = 1'b1; // seen by the first two rising edges
		repeat (2) @(negedge o_clk);
		o_reset = 1'b0; // released on a falling edge like every other input
	end

	always #HALF_PERIOD o_clk = ~o_clk;

endmodule

`default_nettype wire

/* tests/pat_core_tb.sv */
`default_nettype none

module pat_core_tb;
	import pat_pkg::*;

	localparam int TIMEOUT = 200; // cycles allowed while waiting for one out
	localparam logic [DATA_W-1:0] SKIP_OFFSET = 8'd8; // branch over one padded out
	localparam logic [DATA_W-1:0] LAND_VAL = 8'h3c; // out at a branch target
	localparam logic [DATA_W-1:0] FALL_VAL = 8'hc3; // out behind a branch that fails
	localparam logic [DATA_W-1:0] SKIP_VAL = 8'hee; // only seen if a skip goes wrong

	logic clk;
	logic reset;
	logic [PC_W-1:0] pc;
	logic [INSTR_W-1:0] instr;
	logic [DATA_W-1:0] in0, in1, in2;
	logic [DATA_W-1:0] out_data;
	logic out_valid;
	logic flag_z, flag_n;

	logic [INSTR_W-1:0] mem [1 << PC_W]; // program memory model
	logic [INSTR_W-1:0] prog [$]; // program being built
	logic [DATA_W-1:0] expected [$]; // out values in commit order
	int error_count, check_count, test_count;
	logic [31:0] seed;

	pat_clock_gen clock_gen_inst (.o_clk(clk), .o_reset(reset));

	pat_core pat_core_inst (
		.clk(clk), .reset(reset), .o_pc(pc), .i_instr(instr),
		.i_in0(in0), .i_in1(in1), .i_in2(in2),
		.o_out_data(out_data), .o_out_valid(out_valid),
		.o_flag_z(flag_z), .o_flag_n(flag_n)
	);

	// fetch side of the memory, one word per cycle
	always @(negedge clk)
		instr <= mem[pc];

	// ====================================================================
	// instruction words and reference rules
	// ====================================================================
	function automatic logic [INSTR_W-1:0] i8_word(input logic [3:0] opc,
		input logic [REG_ADR_W-1:0] rn, input logic [DATA_W-1:0] imm);
		return {rn, 6'b000000, COND_AL, opc, imm};
	endfunction

	function automatic logic [INSTR_W-1:0] i3_word(input logic [3:0] opc,
		input logic [REG_ADR_W-1:0] rn, input logic [3:0] low);
		return {rn, 6'b000000, COND_AL, OPC_PREFIX, opc, low};
	endfunction

	function automatic logic [INSTR_W-1:0] i0_word(input logic [3:0] opc,
		input logic [REG_ADR_W-1:0] rn);
		return {rn, 6'b000000, COND_AL, OPC_PREFIX, OPC_PREFIX, opc};
	endfunction

	function automatic logic [INSTR_W-1:0] branch_word(input logic [COND_W-1:0] cond);
		return {3'd0, 6'b000000, cond, OPC_I8_BF, SKIP_OFFSET}; // offset from the branch pc
	endfunction

	function automatic logic [DATA_W-1:0] alu_ref(input logic [3:0] opc,
		input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y);
		case (opc)
			OPC_I8_ADD: return x + y; // modulo 256 by width
			OPC_I8_SUB: return x - y;
			OPC_I8_OR: return x | y;
			default: return x & y;
		endcase
	endfunction

	// one bit position per step, fill bit by kind
	function automatic logic [DATA_W-1:0] shift_ref(input logic [3:0] opc,
		input logic [DATA_W-1:0] v, input int amt);
		logic [DATA_W-1:0] r;
		r = v;
		for (int s = 0; s < amt; s++)
		begin
			case (opc)
				OPC_I3_SHLZ: r = {r[DATA_W-2:0], 1'b0};
				OPC_I3_SHLO: r = {r[DATA_W-2:0], 1'b1};
				OPC_I3_SHRZ: r = {1'b0, r[DATA_W-1:1]};
				default: r = {1'b1, r[DATA_W-1:1]}; // shro
			endcase
		end
		return r;
	endfunction

	function automatic logic [DATA_W-1:0] rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[DATA_W-1:0];
	endfunction

	// ====================================================================
	// program building, checks and report
	// ====================================================================
	// three nops behind every word, so no reader ever sees a stale register
	task automatic emit(input logic [INSTR_W-1:0] w);
		prog.push_back(w);
		repeat (3) prog.push_back(INSTR_NOP);
	endtask

	task automatic emit_out(input logic [REG_ADR_W-1:0] rn, input logic [DATA_W-1:0] exp);
		emit(i3_word(OPC_I3_OUT, rn, 4'd0));
		expected.push_back(exp);
	endtask

	task automatic compare_data(input string sig, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			$display("error: %s got 0x%h expected 0x%h", sig, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_pc(input string sig, input logic [PC_W-1:0] got,
		input logic [PC_W-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			$display("error: %s got 0x%h expected 0x%h", sig, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_flags(input logic got_z, input logic got_n,
		input logic exp_z, input logic exp_n);
		check_count++;
		if (got_z !== exp_z || got_n !== exp_n)
		begin
			$display("error: o_flag_z/o_flag_n got 0x%h/0x%h expected 0x%h/0x%h",
				got_z, got_n, exp_z, exp_n);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("test %s finished, %0d errors", name, error_count - errs_before);
	endtask

	// program goes just ahead of the running pc, then each expected out is awaited
	task automatic run_program(input string name);
		logic [PC_W-1:0] adr;
		int waited;
		bit timed_out;
		@(negedge clk);
		adr = pc + 1'b1; // mem[pc] is padding whichever way the driver ran
		foreach (mem[i])
			mem[i] = INSTR_NOP;
		foreach (prog[i])
		begin
			mem[adr] = prog[i];
			adr = adr + 1'b1; // wraps with the pc
		end
		timed_out = 1'b0;
		for (int k = 0; k < expected.size() && !timed_out; k++)
		begin
			waited = 0;
			@(negedge clk);
			while (!out_valid && waited < TIMEOUT)
			begin
				@(negedge clk);
				waited++;
			end
			if (out_valid)
				compare_data("o_out_data", out_data, expected[k]);
			else
			begin
				$display("test %s timed out, out %0d never came", name, k + 1);
				error_count++;
				timed_out = 1'b1;
			end
		end
	endtask

	// ====================================================================
	// tests
	// ====================================================================
	// pc sits at zero through reset, then steps one word per cycle
	task automatic check_reset();
		logic [PC_W-1:0] exp_pc;
		logic rst_seen;
		int errs_before;
		errs_before = error_count;
		exp_pc = '0;
		for (int cyc = 0; cyc < 10; cyc++)
		begin
			@(posedge clk);
			rst_seen = reset; // what fetch saw at this edge
			@(negedge clk);
			exp_pc = rst_seen ? '0 : exp_pc + 1'b1;
			compare_pc("o_pc", pc, exp_pc);
			check_count++;
			if (out_valid !== 1'b0)
			begin
				$display("error: o_out_valid got 0x%h expected 0x0 at cycle %0d",
					out_valid, cyc);
				error_count++;
			end
		end
		compare_flags(flag_z, flag_n, 1'b0, 1'b0); // flags clear after reset
		report_test("reset", errs_before);
	endtask

	task automatic arith_test();
		logic [3:0] ops [4];
		logic [DATA_W-1:0] a, b, c;
		int errs_before;
		errs_before = error_count;
		ops[0] = OPC_I8_ADD;
		ops[1] = OPC_I8_SUB;
		ops[2] = OPC_I8_OR;
		ops[3] = OPC_I8_AND;
		prog.delete();
		expected.delete();
		foreach (ops[k])
		begin
			a = rand_byte();
			b = rand_byte();
			c = rand_byte();
			emit(i8_word(OPC_I8_LDI, 3'd2, b));
			emit(i8_word(OPC_I8_LDI, 3'd3, a));
			emit(i8_word(ops[k], 3'd3, c)); // immediate form
			emit_out(3'd3, alu_ref(ops[k], a, c));
			emit(i8_word(OPC_I8_LDI, 3'd3, a));
			emit(i8_word(ops[k] | 4'b0001, 3'd3, 8'd2)); // register form, b from r2
			emit_out(3'd3, alu_ref(ops[k], a, b));
		end
		run_program("arith");
		report_test("arith", errs_before);
	endtask

	task automatic shift_test();
		logic [3:0] kinds [4];
		logic [2:0] n;
		logic [DATA_W-1:0] v, amt_reg;
		int errs_before;
		errs_before = error_count;
		kinds[0] = OPC_I3_SHLZ;
		kinds[1] = OPC_I3_SHLO;
		kinds[2] = OPC_I3_SHRZ;
		kinds[3] = OPC_I3_SHRO;
		prog.delete();
		expected.delete();
		foreach (kinds[k])
		begin
			for (n = 0; n < 4; n++)
			begin
				v = rand_byte();
				emit(i8_word(OPC_I8_LDI, 3'd3, v));
				emit(i3_word(kinds[k], 3'd3, {1'b0, n})); // imm3 holds amount - 1
				emit_out(3'd3, shift_ref(kinds[k], v, n + 1));
				v = rand_byte();
				amt_reg = rand_byte();
				amt_reg[1:0] = n[1:0]; // upper bits are don't care
				emit(i8_word(OPC_I8_LDI, 3'd4, amt_reg));
				emit(i8_word(OPC_I8_LDI, 3'd3, v));
				emit(i3_word(kinds[k] | 4'b0001, 3'd3, 4'd4)); // amount from r4
				emit_out(3'd3, shift_ref(kinds[k], v, n + 1));
			end
		end
		v = rand_byte();
		emit(i8_word(OPC_I8_LDI, 3'd3, v));
		emit(i0_word(OPC_I0_NOT, 3'd3));
		emit_out(3'd3, ~v);
		run_program("shifts");
		report_test("shifts", errs_before);
	endtask

	task automatic input_test();
		logic [2:0] sels [4];
		logic [DATA_W-1:0] exp;
		int errs_before;
		errs_before = error_count;
		sels[0] = 3'b001;
		sels[1] = 3'b010;
		sels[2] = 3'b100;
		sels[3] = 3'b110; // not one-hot
		@(negedge clk);
		in0 = rand_byte();
		in1 = in0 + 8'd85; // ports always differ
		in2 = in0 + 8'd170;
		prog.delete();
		expected.delete();
		foreach (sels[k])
		begin
			if (sels[k] == 3'b010)
				exp = in1;
			else if (sels[k] == 3'b100)
				exp = in2;
			else
				exp = in0; // port 0 is the default
			emit(i3_word(OPC_I3_IN, 3'd5, {1'b0, sels[k]}));
			emit_out(3'd5, exp);
		end
		run_program("inputs");
		report_test("inputs", errs_before);
	endtask

	task automatic flag_test();
		logic [DATA_W-1:0] vals [3];
		int errs_before;
		errs_before = error_count;
		vals[0] = 8'h00;
		vals[1] = (rand_byte() & 8'h7f) | 8'h01; // positive, nonzero
		vals[2] = rand_byte() | 8'h80; // negative
		foreach (vals[k])
		begin
			prog.delete();
			expected.delete();
			emit(i8_word(OPC_I8_LDI, 3'd1, vals[k]));
			emit(i0_word(OPC_I0_TEST, 3'd1));
			emit_out(3'd1, vals[k]); // flags are settled once this out commits
			run_program("flags");
			compare_flags(flag_z, flag_n, vals[k] == 8'h00, vals[k][DATA_W-1]);
		end
		report_test("flags", errs_before);
	endtask

	// taken: the out right behind the branch is skipped, the target out shows
	task automatic branch_over(input logic [COND_W-1:0] cond);
		emit(branch_word(cond));
		emit(i3_word(OPC_I3_OUT, 3'd5, 4'd0));
		emit_out(3'd6, LAND_VAL);
	endtask

	task automatic branch_fall(input logic [COND_W-1:0] cond);
		emit(branch_word(cond));
		emit_out(3'd7, FALL_VAL);
	endtask

	task automatic branch_test();
		int errs_before;
		errs_before = error_count;
		prog.delete();
		expected.delete();
		emit(i8_word(OPC_I8_LDI, 3'd1, 8'h00));
		emit(i8_word(OPC_I8_LDI, 3'd2, (rand_byte() & 8'h7f) | 8'h01));
		emit(i8_word(OPC_I8_LDI, 3'd3, rand_byte() | 8'h80));
		emit(i8_word(OPC_I8_LDI, 3'd5, SKIP_VAL));
		emit(i8_word(OPC_I8_LDI, 3'd6, LAND_VAL));
		emit(i8_word(OPC_I8_LDI, 3'd7, FALL_VAL));
		emit(i0_word(OPC_I0_TEST, 3'd1)); // z=1 n=0
		branch_over(COND_Z);
		branch_fall(COND_NZ);
		emit(i0_word(OPC_I0_TEST, 3'd2)); // z=0 n=0
		branch_over(COND_NZ);
		branch_fall(COND_Z);
		branch_fall(COND_N);
		emit(i0_word(OPC_I0_TEST, 3'd3)); // z=0 n=1
		branch_over(COND_N);
		branch_over(COND_AL);
		run_program("branches");
		report_test("branches", errs_before);
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================
	initial
	begin
		error_count = 0;
		check_count = 0;
		test_count = 0;
		instr = INSTR_NOP;
		in0 = '0;
		in1 = '0;
		in2 = '0;
		foreach (mem[i])
			mem[i] = INSTR_NOP;
		seed = 32'h3fb1;
		void'($urandom(seed)); // one seed for the whole run
		check_reset();
		arith_test();
		shift_test();
		input_test();
		flag_test();
		branch_test();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/pat_pkg.sv
hw/pat_fetch.sv
hw/pat_decode.sv
hw/pat_regfile.sv
hw/pat_execute.sv
hw/pat_result.sv
hw/pat_core.sv
tests/pat_clock_gen.sv
tests/pat_core_tb.sv
